/* axi_legalizer.f */
verilog/legalizer_pkg.sv
verilog/legalizer_ctrl.sv
verilog/burst_stepper.sv
verilog/legalizer_top.sv
dv/legalizer_checker.sv
dv/legalizer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the legalizer testbench with Verilator.
# Exit status is nonzero when the build fails or the run reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv \
    --top-module legalizer_tb \
    --Mdir obj_dir -o legalizer_sim \
    -f axi_legalizer.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/legalizer_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation failed"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if ! grep -q "=== PASS ===" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

/* dv/legalizer_tb.sv */
// self-checking testbench for legalizer_top: random 1D transfers against a reference burst split
`timescale 1ns/10ps
`default_nettype none

module legalizer_tb
    import legalizer_pkg::*;
;
    // full page for 256 beats of 4 bytes is 1 KiB
    localparam int unsigned PAGE_LIMIT_W = 10;
    localparam int unsigned NUM_RAND     = 12;

    logic      clk_i;
    logic      rst_i;
    xfer_req_t req_i;
    logic      valid_i;
    logic      ready_o;
    r_req_t    r_req_o;
    logic      r_valid_o;
    logic      r_ready_i;
    w_req_t    w_req_o;
    logic      w_valid_o;
    logic      w_ready_i;
    logic      flush_i;
    logic      kill_i;
    logic      r_busy_o;
    logic      w_busy_o;

    integer      seed;
    int unsigned exp_total;
    int unsigned cycle_cnt;
    int unsigned err_cnt;
    logic        bp_en;
    r_req_t      exp_r[$];
    w_req_t      exp_w[$];

    legalizer_top #(.MaxBeatsPerBurst(256)) dut_i (.*);

    bind legalizer_top legalizer_checker #(.MaxBeatsPerBurst(MaxBeatsPerBurst)) u_checker (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (valid_i),
        .ready_o    (ready_o),
        .r_valid_o  (r_valid_o),
        .w_valid_o  (w_valid_o),
        .r_ready_i  (r_ready_i),
        .w_ready_i  (w_ready_i),
        .flush_i    (flush_i),
        .r_len_i    (r_req_o.ax.len),
        .w_len_i    (w_req_o.ax.len),
        .r_addr_i   (r_req_o.ax.addr),
        .w_addr_i   (w_req_o.ax.addr),
        .decouple_i (u_ctrl.opt_q.decouple_rw)
    );

    always #5 clk_i = ~clk_i;

    // ------------------------------------------------------------------
    // checking helpers
    // ------------------------------------------------------------------
    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(string msg);
        err_cnt++;
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // page bytes per side, 1 KiB unless reduced
    function automatic int unsigned page_bytes(page_cfg_t cfg);
        int unsigned w;
        w = cfg.reduce_len ? 2 + 32'(cfg.max_llen) : PAGE_LIMIT_W;
        if (w > PAGE_LIMIT_W) begin
            w = PAGE_LIMIT_W;
        end
        return 32'(1) << w;
    endfunction

    function automatic ax_req_t make_ax(addr_t a, int unsigned n);
        ax_req_t ax;
        ax.addr = {a[31:2], 2'b00};
        ax.len  = 8'((n + 32'(a[1:0]) - 1) / 4);
        ax.size = 3'd2;
        return ax;
    endfunction

    function automatic dp_req_t make_dp(addr_t a, int unsigned n);
        dp_req_t dp;
        dp.offset = a[1:0];
        dp.tailer = 2'((n + 32'(a[1:0])) % 4);
        return dp;
    endfunction

    // pushes the expected read and write burst sequences of one transfer
    function automatic void split_bursts(addr_t src, addr_t dst, len_t length,
                                         page_cfg_t rc, page_cfg_t wc, logic decouple);
        addr_t       ra;
        addr_t       wa;
        int unsigned rr;
        int unsigned wr;
        int unsigned pr;
        int unsigned pw;
        int unsigned br;
        int unsigned bw;
        int unsigned n;
        offset_t     sh;
        r_req_t      rq;
        w_req_t      wq;
        sh = src[1:0] - dst[1:0];
        ra = src;
        wa = dst;
        rr = length;
        wr = length;
        pr = page_bytes(rc);
        pw = page_bytes(wc);
        while (rr > 0 || wr > 0) begin
            br = pr - (ra % pr);
            bw = pw - (wa % pw);
            // coupled pairs move the same bytes up to the nearer boundary
            if (!decouple) begin
                br = (br < bw) ? br : bw;
                bw = br;
            end
            if (rr > 0) begin
                n = (rr <= br) ? rr : br;
                rq.ax    = make_ax(ra, n);
                rq.dp    = make_dp(ra, n);
                rq.shift = sh;
                exp_r.push_back(rq);
                ra = ra + n;
                rr = rr - n;
                exp_total++;
            end
            if (wr > 0) begin
                n = (wr <= bw) ? wr : bw;
                wq.ax   = make_ax(wa, n);
                wq.dp   = make_dp(wa, n);
                wq.last = (wr <= bw);
                exp_w.push_back(wq);
                wa = wa + n;
                wr = wr - n;
                exp_total++;
            end
        end
    endfunction

    // ------------------------------------------------------------------
    // monitor and compare
    // ------------------------------------------------------------------
    always @(posedge clk_i) begin
        if (!rst_i) begin
            // bursts in a kill cycle belong to the abandoned transfer
            if (kill_i) begin
                exp_r.delete();
                exp_w.delete();
            end else begin
                if (r_valid_o) begin
                    if (exp_r.size() == 0) begin
                        abort_run("unexpected read burst with no transfer pending");
                    end
                    check_value("r_req_o.ax", 64'(r_req_o.ax), 64'(exp_r[0].ax));
                    check_value("r_req_o.dp", 64'(r_req_o.dp), 64'(exp_r[0].dp));
                    check_value("r_req_o.shift", 64'(r_req_o.shift), 64'(exp_r[0].shift));
                    void'(exp_r.pop_front());
                end
                if (w_valid_o) begin
                    if (exp_w.size() == 0) begin
                        abort_run("unexpected write burst with no transfer pending");
                    end
                    check_value("w_req_o.ax", 64'(w_req_o.ax), 64'(exp_w[0].ax));
                    check_value("w_req_o.dp", 64'(w_req_o.dp), 64'(exp_w[0].dp));
                    check_value("w_req_o.last", 64'(w_req_o.last), 64'(exp_w[0].last));
                    void'(exp_w.pop_front());
                end
            end
            // accepted transfer queues its expected bursts
            if (valid_i && ready_o) begin
                split_bursts(req_i.src_addr, req_i.dst_addr, req_i.length,
                             '{reduce_len: req_i.opt.src_reduce_len,
                               max_llen: req_i.opt.src_max_llen},
                             '{reduce_len: req_i.opt.dst_reduce_len,
                               max_llen: req_i.opt.dst_max_llen},
                             req_i.opt.decouple_rw);
            end
        end
    end

    // timeout scales with the bursts expected so far
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > 20 * exp_total + 2000) begin
            abort_run("simulation hung, bursts stopped arriving before the limit");
        end
    end

    // random back-pressure and flush pulses
    always @(negedge clk_i) begin
        if (bp_en) begin
            r_ready_i = (($random(seed) & 3) != 0);
            w_ready_i = (($random(seed) & 3) != 0);
            flush_i   = (($random(seed) & 15) == 0);
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic offer_xfer(addr_t src, addr_t dst, len_t length, beo_opt_t opt);
        @(negedge clk_i);
        req_i   = '{length: length, src_addr: src, dst_addr: dst, opt: opt};
        valid_i = 1'b1;
        forever begin
            @(posedge clk_i);
            if (ready_o) begin
                break;
            end
        end
        @(negedge clk_i);
        valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        forever begin
            @(negedge clk_i);
            if (exp_r.size() == 0 && exp_w.size() == 0 && !r_busy_o && !w_busy_o) begin
                break;
            end
        end
    endtask

    task automatic random_xfer(logic decouple);
        beo_opt_t opt;
        addr_t    src;
        addr_t    dst;
        len_t     length;
        src    = $random(seed);
        dst    = $random(seed);
        length = 1 + ($unsigned($random(seed)) % 3000);
        opt.decouple_rw    = decouple;
        opt.src_reduce_len = 1'($random(seed));
        opt.dst_reduce_len = 1'($random(seed));
        opt.src_max_llen   = 3'(2 + ($unsigned($random(seed)) % 6));
        opt.dst_max_llen   = 3'(2 + ($unsigned($random(seed)) % 6));
        offer_xfer(src, dst, length, opt);
        wait_idle();
    endtask

    initial begin
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        req_i     = '0;
        valid_i   = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        flush_i   = 1'b0;
        kill_i    = 1'b0;
        bp_en     = 1'b0;
        seed      = 621;
        exp_total = 0;
        cycle_cnt = 0;
        err_cnt   = 0;
        repeat (5) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        // idle state after reset
        check_value("r_valid_o", 64'(r_valid_o), 64'h0);
        check_value("w_valid_o", 64'(w_valid_o), 64'h0);
        check_value("r_busy_o", 64'(r_busy_o), 64'h0);
        check_value("w_busy_o", 64'(w_busy_o), 64'h0);
        check_value("ready_o", 64'(ready_o), 64'h1);

        // short transfer inside one page
        offer_xfer(32'h0000_1003, 32'h0000_2001, 32'd20, '0);
        wait_idle();

        // several KiB coupled, unaligned and different offsets
        offer_xfer(32'h1000_0105, 32'h3002_0a3e, 32'd5000, '0);
        wait_idle();

        // decoupled with reduced pages
        repeat (6) random_xfer(1'b1);

        // back-pressure and flush in both modes
        bp_en = 1'b1;
        repeat (NUM_RAND) random_xfer(1'($random(seed)));
        @(negedge clk_i);
        bp_en     = 1'b0;
        r_ready_i = 1'b1;
        w_ready_i = 1'b1;
        flush_i   = 1'b0;
        wait_idle();

        // kill mid-transfer, steppers idle one cycle later
        offer_xfer(32'h0000_4010, 32'h0008_0002, 32'd4096, '0);
        repeat (3) @(negedge clk_i);
        kill_i = 1'b1;
        @(negedge clk_i);
        kill_i = 1'b0;
        check_value("r_busy_o", 64'(r_busy_o), 64'h0);
        check_value("w_busy_o", 64'(w_busy_o), 64'h0);

        // kill with a new transfer offered in the same cycle
        offer_xfer(32'h0000_6001, 32'h0009_0003, 32'd3000, '0);
        repeat (2) @(negedge clk_i);
        req_i = '{length: 32'd2100, src_addr: 32'h0001_03fe, dst_addr: 32'h0002_0001,
                  opt: '0};
        valid_i = 1'b1;
        kill_i  = 1'b1;
        @(negedge clk_i);
        valid_i = 1'b0;
        kill_i  = 1'b0;
        wait_idle();
        repeat (4) @(negedge clk_i);

        if (err_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/legalizer_checker.sv */
// concurrent handshake and descriptor checks, bound onto legalizer_top from the testbench
`timescale 1ns/10ps
`default_nettype none

module legalizer_checker
    import legalizer_pkg::*;
#(
    parameter int unsigned MaxBeatsPerBurst = 256
) (
    input wire              clk_i,
    input wire              rst_i,
    input wire              valid_i,
    input wire              ready_o,
    input wire              r_valid_o,
    input wire              w_valid_o,
    input wire              r_ready_i,
    input wire              w_ready_i,
    input wire              flush_i,
    input wire [7:0]        r_len_i,
    input wire [7:0]        w_len_i,
    input wire [ADDR_W-1:0] r_addr_i,
    input wire [ADDR_W-1:0] w_addr_i,
    input wire              decouple_i
);

    // hard page of the bus, 4 KiB or the longest burst
    localparam int unsigned PAGE_BYTES = (MaxBeatsPerBurst * STRB_W > (1 << MAX_PAGE_W)) ?
                                         (1 << MAX_PAGE_W) : MaxBeatsPerBurst * STRB_W;

    // ------------------------------------------------------------------
    // handshake rules
    // ------------------------------------------------------------------
    // a burst only leaves with its own ready and outside flush
    a_r_valid_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_o |-> (r_ready_i && !flush_i)) else $error("read valid without ready");
    a_w_valid_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        w_valid_o |-> (w_ready_i && !flush_i)) else $error("write valid without ready");

    // flush blocks transfer acceptance
    a_no_accept_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |-> !(ready_o && valid_i)) else $error("transfer taken during flush");

    // ------------------------------------------------------------------
    // descriptor legality
    // ------------------------------------------------------------------
    // a burst never crosses a page, which also keeps len below MaxBeatsPerBurst
    a_r_page: assert property (@(posedge clk_i) disable iff (rst_i)
        r_valid_o |-> ((r_addr_i % PAGE_BYTES) + STRB_W * (32'(r_len_i) + 1) <= PAGE_BYTES))
        else $error("read burst crosses a page");
    a_w_page: assert property (@(posedge clk_i) disable iff (rst_i)
        w_valid_o |-> ((w_addr_i % PAGE_BYTES) + STRB_W * (32'(w_len_i) + 1) <= PAGE_BYTES))
        else $error("write burst crosses a page");

    // lock step pairs in coupled mode
    a_coupled: assert property (@(posedge clk_i) disable iff (rst_i)
        !decouple_i |-> (r_valid_o == w_valid_o)) else $error("coupled valids differ");

endmodule

`default_nettype wire

/* verilog/legalizer_top.sv */
// AXI4 burst legalizer top: splits one DMA transfer into page-legal read and write bursts
`timescale 1ns/10ps
`default_nettype none

module legalizer_top
    import legalizer_pkg::*;
#(
    // 256 for AXI4, 16 for AXI3
    parameter int unsigned MaxBeatsPerBurst = 256
) (
    input  wire        clk_i,
    input  wire        rst_i,

    // transfer input
    input  xfer_req_t  req_i,
    input  wire        valid_i,
    output logic       ready_o,

    // read bursts
    output r_req_t     r_req_o,
    output logic       r_valid_o,
    input  wire        r_ready_i,

    // write bursts
    output w_req_t     w_req_o,
    output logic       w_valid_o,
    input  wire        w_ready_i,

    // hold emission / abandon the active transfer
    input  wire        flush_i,
    input  wire        kill_i,

    output logic       r_busy_o,
    output logic       w_busy_o
);

    // ------------------------------------------------------------------
    // internal wiring
    // ------------------------------------------------------------------
    logic      load;
    logic      r_step;
    logic      w_step;
    logic      r_go;
    logic      w_go;
    logic      r_done;
    logic      w_done;
    page_cfg_t r_cfg;
    page_cfg_t w_cfg;
    page_len_t r_bytes_possible;
    page_len_t w_bytes_possible;
    page_len_t r_bytes_to_pb;
    page_len_t w_bytes_to_pb;
    offset_t   shift;
    ax_req_t   r_ax;
    ax_req_t   w_ax;
    dp_req_t   r_dp;
    dp_req_t   w_dp;

    legalizer_ctrl u_ctrl (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .req_i              (req_i),
        .valid_i            (valid_i),
        .ready_o            (ready_o),
        .r_ready_i          (r_ready_i),
        .w_ready_i          (w_ready_i),
        .flush_i            (flush_i),
        .kill_i             (kill_i),
        .r_bytes_to_pb_i    (r_bytes_to_pb),
        .w_bytes_to_pb_i    (w_bytes_to_pb),
        .r_done_i           (r_done),
        .w_done_i           (w_done),
        .r_valid_o          (r_go),
        .w_valid_o          (w_go),
        .load_o             (load),
        .r_step_o           (r_step),
        .w_step_o           (w_step),
        .r_cfg_o            (r_cfg),
        .w_cfg_o            (w_cfg),
        .r_bytes_possible_o (r_bytes_possible),
        .w_bytes_possible_o (w_bytes_possible),
        .shift_o            (shift)
    );

    // source side
    burst_stepper #(
        .MaxBeatsPerBurst (MaxBeatsPerBurst)
    ) u_read_stepper (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .load_i           (load),
        .step_i           (r_step),
        .kill_i           (kill_i),
        .addr_i           (req_i.src_addr),
        .length_i         (req_i.length),
        .cfg_i            (r_cfg),
        .bytes_possible_i (r_bytes_possible),
        .bytes_to_pb_o    (r_bytes_to_pb),
        .done_o           (r_done),
        .busy_o           (r_busy_o),
        .ax_o             (r_ax),
        .dp_o             (r_dp)
    );

    // destination side
    burst_stepper #(
        .MaxBeatsPerBurst (MaxBeatsPerBurst)
    ) u_write_stepper (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .load_i           (load),
        .step_i           (w_step),
        .kill_i           (kill_i),
        .addr_i           (req_i.dst_addr),
        .length_i         (req_i.length),
        .cfg_i            (w_cfg),
        .bytes_possible_i (w_bytes_possible),
        .bytes_to_pb_o    (w_bytes_to_pb),
        .done_o           (w_done),
        .busy_o           (w_busy_o),
        .ax_o             (w_ax),
        .dp_o             (w_dp)
    );

    // ------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------
    // a side only emits while it still holds part of a transfer
    assign r_valid_o = r_go & r_busy_o;
    assign w_valid_o = w_go & w_busy_o;

    assign r_req_o = '{ax: r_ax, dp: r_dp, shift: shift};
    // final write burst is the one that finishes the write stepper
    assign w_req_o = '{ax: w_ax, dp: w_dp, last: w_done};

endmodule

`default_nettype wire

/* verilog/burst_stepper.sv */
// one side of the legalizer: walks the transfer page by page and forms each burst descriptor
`timescale 1ns/10ps
`default_nettype none

module burst_stepper
    import legalizer_pkg::*;
#(
    parameter int unsigned MaxBeatsPerBurst = 256
) (
    input  wire        clk_i,
    input  wire        rst_i,

    // state control from the controller
    input  wire        load_i,
    input  wire        step_i,
    input  wire        kill_i,

    // new transfer, sampled on load
    input  addr_t      addr_i,
    input  len_t       length_i,

    // page shaping and permitted burst size
    input  page_cfg_t  cfg_i,
    input  page_len_t  bytes_possible_i,

    // feedback to the controller
    output page_len_t  bytes_to_pb_o,
    output logic       done_o,
    output logic       busy_o,

    // current burst
    output ax_req_t    ax_o,
    output dp_req_t    dp_o
);

    // ------------------------------------------------------------------
    // page geometry
    // ------------------------------------------------------------------
    // hard page: 4 KiB or the longest burst, whichever is smaller
    localparam int unsigned PAGE_BYTES = (MaxBeatsPerBurst * STRB_W > (1 << MAX_PAGE_W)) ?
                                         (1 << MAX_PAGE_W) : MaxBeatsPerBurst * STRB_W;
    localparam int unsigned PAGE_AW    = $clog2(PAGE_BYTES);

    // mutable transfer state
    addr_t      addr_q;
    len_t       length_q;
    logic       valid_q;

    // page arithmetic
    logic [3:0] page_w;
    page_len_t  page_size;
    page_len_t  page_off;

    // burst sizing
    logic       fits;
    page_len_t  num_bytes;
    page_len_t  beats_m1;
    offset_t    addr_off;

    // page width in bits, optionally reduced per side
    always_comb begin
        page_w = 4'(OFFSET_W) + (cfg_i.reduce_len ? {1'b0, cfg_i.max_llen} : 4'd8);
        // never beyond the hard page
        if (page_w > 4'(PAGE_AW)) begin
            page_w = 4'(PAGE_AW);
        end
    end

    assign page_size = page_len_t'(1) << page_w;

    // low address bits below the variable page width
    always_comb begin
        page_off = '0;
        for (int i = 0; i < PAGE_AW; i++) begin
            page_off[i] = (page_w > i) ? addr_q[i] : 1'b0;
        end
    end

    // distance to the next page boundary
    assign bytes_to_pb_o = page_size - page_off;

    // ------------------------------------------------------------------
    // burst sizing
    // ------------------------------------------------------------------
    // remaining bytes fit into this burst, so this is the final one
    assign fits      = (length_q <= LEN_W'(bytes_possible_i));
    assign num_bytes = fits ? length_q[MAX_PAGE_W:0] : bytes_possible_i;

    // idle counts as done so a new transfer can enter, kill forces it too
    assign done_o    = ~valid_q | fits | kill_i;
    assign busy_o    = valid_q;

    // ------------------------------------------------------------------
    // descriptors
    // ------------------------------------------------------------------
    assign addr_off = addr_q[OFFSET_W-1:0];
    // bytes plus leading offset never pass the page, so len stays in range
    assign beats_m1 = num_bytes + page_len_t'(addr_off) - page_len_t'(1);

    assign ax_o.addr = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign ax_o.len  = beats_m1[OFFSET_W +: AX_LEN_W];
    // always full bus width beats
    assign ax_o.size = AX_SIZE_W'(OFFSET_W);

    assign dp_o.offset = addr_off;
    // wraps to zero when the last beat is full
    assign dp_o.tailer = offset_t'(num_bytes + page_len_t'(addr_off));

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q   <= '0;
            length_q <= '0;
            valid_q  <= 1'b0;
        end else if (load_i) begin
            // load overrides a kill in the same cycle
            addr_q   <= addr_i;
            length_q <= length_i;
            valid_q  <= 1'b1;
        end else if (kill_i) begin
            addr_q   <= '0;
            length_q <= '0;
            valid_q  <= 1'b0;
        end else if (step_i && valid_q) begin
            if (fits) begin
                // final burst handed over
                valid_q <= 1'b0;
            end else begin
                addr_q   <= addr_q + ADDR_W'(num_bytes);
                length_q <= length_q - LEN_W'(num_bytes);
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/legalizer_ctrl.sv */
// legalizer flow control: latches transfer options, picks the burst size per side and drives the handshakes
`timescale 1ns/10ps
`default_nettype none

module legalizer_ctrl
    import legalizer_pkg::*;
(
    input  wire        clk_i,
    input  wire        rst_i,

    // transfer input
    input  xfer_req_t  req_i,
    input  wire        valid_i,
    output logic       ready_o,

    // downstream readiness and global controls
    input  wire        r_ready_i,
    input  wire        w_ready_i,
    input  wire        flush_i,
    input  wire        kill_i,

    // stepper feedback
    input  page_len_t  r_bytes_to_pb_i,
    input  page_len_t  w_bytes_to_pb_i,
    input  wire        r_done_i,
    input  wire        w_done_i,

    // handshake qualifiers, still ungated by stepper occupancy
    output logic       r_valid_o,
    output logic       w_valid_o,

    // stepper control
    output logic       load_o,
    output logic       r_step_o,
    output logic       w_step_o,
    output page_cfg_t  r_cfg_o,
    output page_cfg_t  w_cfg_o,
    output page_len_t  r_bytes_possible_o,
    output page_len_t  w_bytes_possible_o,
    output offset_t    shift_o
);

    // latched options of the active transfer
    beo_opt_t  opt_q;
    // src to dst byte shift of the active transfer
    offset_t   shift_q;
    // boundary that comes first over both sides
    page_len_t c_bytes_to_pb;
    // step qualifiers before kill is folded in
    logic      r_go;
    logic      w_go;

    // ------------------------------------------------------------------
    // refill
    // ------------------------------------------------------------------
    // a new transfer only enters once both sides are done
    assign ready_o = r_done_i & w_done_i & r_ready_i & w_ready_i & ~flush_i;
    // load wins over kill inside the steppers
    assign load_o  = valid_i & ready_o;

    // options register, cleared by reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opt_q <= '0;
        end else if (load_o) begin
            opt_q <= req_i.opt;
        end
    end

    // src offset minus dst offset, latched with each transfer
    always_ff @(posedge clk_i) begin
        if (load_o) begin
            shift_q <= req_i.src_addr[OFFSET_W-1:0] - req_i.dst_addr[OFFSET_W-1:0];
        end
    end

    assign shift_o = shift_q;

    // page shaping handed to each stepper
    assign r_cfg_o = '{reduce_len: opt_q.src_reduce_len, max_llen: opt_q.src_max_llen};
    assign w_cfg_o = '{reduce_len: opt_q.dst_reduce_len, max_llen: opt_q.dst_max_llen};

    // ------------------------------------------------------------------
    // burst size selection
    // ------------------------------------------------------------------
    // coupled pairs must move the same bytes, so take the nearer boundary
    assign c_bytes_to_pb = (r_bytes_to_pb_i > w_bytes_to_pb_i) ? w_bytes_to_pb_i
                                                               : r_bytes_to_pb_i;

    // decoupled sides just follow their own page
    assign r_bytes_possible_o = opt_q.decouple_rw ? r_bytes_to_pb_i : c_bytes_to_pb;
    assign w_bytes_possible_o = opt_q.decouple_rw ? w_bytes_to_pb_i : c_bytes_to_pb;

    // ------------------------------------------------------------------
    // flow control
    // ------------------------------------------------------------------
    always_comb begin
        if (opt_q.decouple_rw) begin
            // each side runs on its own ready
            r_go = r_ready_i & ~flush_i;
            w_go = w_ready_i & ~flush_i;
        end else begin
            // lock step, both sides wait on both readies
            r_go = r_ready_i & w_ready_i & ~flush_i;
            w_go = r_go;
        end
    end

    // kill must reach the state registers regardless of back-pressure
    assign r_step_o  = r_go | kill_i;
    assign w_step_o  = w_go | kill_i;

    // a burst is handed over whenever its side advances normally
    assign r_valid_o = r_go;
    assign w_valid_o = w_go;

endmodule

`default_nettype wire

/* verilog/legalizer_pkg.sv */
// shared widths, limits and packed request structs; import into every legalizer module and the testbench
`default_nettype none

package legalizer_pkg;

    // ------------------------------------------------------------------
    // widths and limits
    // ------------------------------------------------------------------
    // bus and transfer widths
    localparam int unsigned ADDR_W     = 32;
    localparam int unsigned LEN_W      = 32;
    localparam int unsigned DATA_W     = 32;
    // byte lanes and in-beat offset follow the data width
    localparam int unsigned STRB_W     = DATA_W / 8;
    localparam int unsigned OFFSET_W   = $clog2(STRB_W);
    // an AXI page is at most 4 KiB, so 12 bits of page offset
    localparam int unsigned MAX_PAGE_W = 12;
    // AXI4 ax channel field widths
    localparam int unsigned AX_LEN_W   = 8;
    localparam int unsigned AX_SIZE_W  = 3;

    // ------------------------------------------------------------------
    // scalar types
    // ------------------------------------------------------------------
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    // one extra bit so a full page length fits
    typedef logic [MAX_PAGE_W:0] page_len_t;

    // ------------------------------------------------------------------
    // transfer request
    // ------------------------------------------------------------------
    // burst options; max_llen is log2 of beats per reduced page
    typedef struct packed {
        logic       decouple_rw;
        logic       src_reduce_len;
        logic       dst_reduce_len;
        logic [2:0] src_max_llen;
        logic [2:0] dst_max_llen;
    } beo_opt_t;

    // generic 1D transfer
    typedef struct packed {
        len_t     length;
        addr_t    src_addr;
        addr_t    dst_addr;
        beo_opt_t opt;
    } xfer_req_t;

    // page shaping for one side
    typedef struct packed {
        logic       reduce_len;
        logic [2:0] max_llen;
    } page_cfg_t;

    // ------------------------------------------------------------------
    // burst descriptors
    // ------------------------------------------------------------------
    // ax channel subset: beat aligned address, beats minus one, beat size
    typedef struct packed {
        addr_t                addr;
        logic [AX_LEN_W-1:0]  len;
        logic [AX_SIZE_W-1:0] size;
    } ax_req_t;

    // datapath: first valid byte and end byte of the last beat
    typedef struct packed {
        offset_t offset;
        offset_t tailer;
    } dp_req_t;

    // read burst carries the src to dst realignment shift
    typedef struct packed {
        ax_req_t ax;
        dp_req_t dp;
        offset_t shift;
    } r_req_t;

    // write burst flags the final burst of the transfer
    typedef struct packed {
        ax_req_t ax;
        dp_req_t dp;
        logic    last;
    } w_req_t;

endpackage

`default_nettype wire
